// ==== include/mouse_params.svh ====
`ifndef MOUSE_PARAMS_SVH
`define MOUSE_PARAMS_SVH

// Screen coordinate width in bits
`define COORD_W 12
// Signed movement delta, sign bit plus packet byte
`define DELTA_W 9
// Left, right, middle
`define BTN_W 3

// Movement record buffer entries
`define MOVE_FIFO_DEPTH 4

// Window after reset, minimums reset to 0
`define DEFAULT_MAX_X 1023
`define DEFAULT_MAX_Y 767

// Game window
`define GAME_MAX_X 800
`define GAME_MAX_Y 600
`define GAME_MIN_X 400
`define GAME_MIN_Y 200

`endif

// ==== src/mouse_pkg.sv ====
`default_nettype none

`include "mouse_params.svh"

package mouse_pkg;

    ////////////////////////////////////////
    // PS/2 packet header layout
    ////////////////////////////////////////

    // Buttons in bits 0 to 2, left first
    localparam int HDR_BTN_LSB   = 0;
    // Always set in a valid header byte
    localparam int HDR_SYNC_BIT  = 3;
    // Delta sign bits
    localparam int HDR_XSIGN_BIT = 4;
    localparam int HDR_YSIGN_BIT = 5;

    ////////////////////////////////////////
    // Movement record
    ////////////////////////////////////////

    typedef struct packed {
        logic signed [`DELTA_W-1:0] dx;
        // Positive dy means upward motion
        logic signed [`DELTA_W-1:0] dy;
        logic        [`BTN_W-1:0]   buttons;
    } move_t;

endpackage

`default_nettype wire

// ==== src/screen_pkg.sv ====
`default_nettype none

`include "mouse_params.svh"

package screen_pkg;

    ////////////////////////////////////////
    // Screen coordinates
    ////////////////////////////////////////

    // Unsigned pixel position
    typedef logic [`COORD_W-1:0] coord_t;

    // Window limit selection
    // Idle first, then the write order of the limits
    typedef enum logic [2:0] {
        LIM_IDLE  = 3'd0,
        LIM_MAX_X = 3'd1,
        LIM_MAX_Y = 3'd2,
        LIM_MIN_X = 3'd3,
        LIM_MIN_Y = 3'd4
    } limit_sel_t;

endpackage

`default_nettype wire

// ==== src/mouse_constrainer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module mouse_constrainer
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               game_on,
    output screen_pkg::coord_t      value,
    output logic                    setmax_x,
    output logic                    setmax_y,
    output logic                    setmin_x,
    output logic                    setmin_y
);

    screen_pkg::limit_sel_t state;
    screen_pkg::limit_sel_t state_nxt;
    screen_pkg::coord_t     value_nxt;

    ////////////////////////////////////////
    // State and registered outputs
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= screen_pkg::LIM_IDLE;
            value    <= '0;
            setmax_x <= 1'b0;
            setmax_y <= 1'b0;
            setmin_x <= 1'b0;
            setmin_y <= 1'b0;
        end
        else
        begin
            state    <= state_nxt;
            value    <= value_nxt;
            // One strobe per limit state, so at most one is high
            setmax_x <= (state == screen_pkg::LIM_MAX_X);
            setmax_y <= (state == screen_pkg::LIM_MAX_Y);
            setmin_x <= (state == screen_pkg::LIM_MIN_X);
            setmin_y <= (state == screen_pkg::LIM_MIN_Y);
        end
    end

    ////////////////////////////////////////
    // Next state and limit value
    ////////////////////////////////////////

    always_comb
    begin
        state_nxt = screen_pkg::LIM_IDLE;
        value_nxt = '0;
        case (state)
            // Wait for the game to start, recheck after every pass
            screen_pkg::LIM_IDLE:
            begin
                state_nxt = game_on ? screen_pkg::LIM_MAX_X : screen_pkg::LIM_IDLE;
            end
            screen_pkg::LIM_MAX_X:
            begin
                value_nxt = screen_pkg::coord_t'(`GAME_MAX_X);
                state_nxt = screen_pkg::LIM_MAX_Y;
            end
            screen_pkg::LIM_MAX_Y:
            begin
                value_nxt = screen_pkg::coord_t'(`GAME_MAX_Y);
                state_nxt = screen_pkg::LIM_MIN_X;
            end
            screen_pkg::LIM_MIN_X:
            begin
                value_nxt = screen_pkg::coord_t'(`GAME_MIN_X);
                state_nxt = screen_pkg::LIM_MIN_Y;
            end
            // Last limit, back to idle
            screen_pkg::LIM_MIN_Y:
            begin
                value_nxt = screen_pkg::coord_t'(`GAME_MIN_Y);
                state_nxt = screen_pkg::LIM_IDLE;
            end
            default:
            begin
                state_nxt = screen_pkg::LIM_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/move_packetizer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module move_packetizer
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic [7:0]     byte_data,
    input  wire logic           byte_valid,
    output logic                byte_ready,
    output mouse_pkg::move_t    move_data,
    output logic                move_valid,
    input  wire logic           move_ready
);

    // Packet position with 0 for the header, 1 for x delta and 2 for y delta
    logic [1:0] byte_idx;
    // Header and x byte kept until the y byte arrives
    logic [7:0] hdr_byte;
    logic [7:0] x_byte;
    logic       byte_fire;
    logic       hdr_ok;

    // Stall bytes while a finished record waits
    assign byte_ready = ~move_valid;
    assign byte_fire  = byte_valid & byte_ready;
    // Sync bit marks a header byte
    assign hdr_ok     = byte_data[mouse_pkg::HDR_SYNC_BIT];

    ////////////////////////////////////////
    // Byte index and record handshake
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            byte_idx   <= 2'd0;
            move_valid <= 1'b0;
        end
        else
        begin
            if (move_valid && move_ready)
                move_valid <= 1'b0;
            if (byte_fire)
            begin
                case (byte_idx)
                    // Drop bytes until a header lines up
                    2'd0:    byte_idx <= hdr_ok ? 2'd1 : 2'd0;
                    2'd1:    byte_idx <= 2'd2;
                    default:
                    begin
                        byte_idx   <= 2'd0;
                        move_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Packet payload capture
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (byte_fire)
        begin
            if (byte_idx == 2'd0)
                hdr_byte <= byte_data;
            if (byte_idx == 2'd1)
                x_byte <= byte_data;
            // Third byte completes the record
            if (byte_idx == 2'd2)
            begin
                move_data.dx      <= $signed({hdr_byte[mouse_pkg::HDR_XSIGN_BIT], x_byte});
                move_data.dy      <= $signed({hdr_byte[mouse_pkg::HDR_YSIGN_BIT], byte_data});
                move_data.buttons <= hdr_byte[mouse_pkg::HDR_BTN_LSB +: `BTN_W];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/move_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module move_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
)
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  payload_t    in_data,
    input  wire logic   in_valid,
    output logic        in_ready,
    output payload_t    out_data,
    output logic        out_valid,
    input  wire logic   out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    // Full blocks the writer, empty hides the head entry
    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    // Show-ahead head entry
    assign out_data  = mem[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    ////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Wrap explicitly, depth need not be a power of two
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop keep the count
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

// ==== src/position_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module position_tracker
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           game_on,
    input  screen_pkg::coord_t  value,
    input  wire logic           setmax_x,
    input  wire logic           setmax_y,
    input  wire logic           setmin_x,
    input  wire logic           setmin_y,
    input  mouse_pkg::move_t    move_data,
    input  wire logic           move_valid,
    output logic                move_ready,
    output screen_pkg::coord_t  pos_x,
    output screen_pkg::coord_t  pos_y,
    output logic [`BTN_W-1:0]   buttons,
    output logic                pos_valid
);

    screen_pkg::coord_t max_x;
    screen_pkg::coord_t max_y;
    screen_pkg::coord_t min_x;
    screen_pkg::coord_t min_y;
    // Two extra bits hold the sign and the carry of a delta
    logic signed [`COORD_W+1:0] sum_x;
    logic signed [`COORD_W+1:0] sum_y;
    logic                       move_fire;

    // Saturate a signed sum into [lo, hi]
    function automatic screen_pkg::coord_t clamp(
        input logic signed [`COORD_W+1:0] sum,
        input screen_pkg::coord_t         lo,
        input screen_pkg::coord_t         hi
    );
        logic signed [`COORD_W+1:0] lo_s;
        logic signed [`COORD_W+1:0] hi_s;
        lo_s = $signed({2'b00, lo});
        hi_s = $signed({2'b00, hi});
        if (sum < lo_s)
            return lo;
        else if (sum > hi_s)
            return hi;
        else
            return sum[`COORD_W-1:0];
    endfunction

    // Moves only drain during a game
    assign move_ready = game_on;
    assign move_fire  = move_valid & move_ready;

    // PS/2 y grows upward, screen y grows downward
    assign sum_x = $signed({2'b00, pos_x}) + move_data.dx;
    assign sum_y = $signed({2'b00, pos_y}) - move_data.dy;

    ////////////////////////////////////////
    // Limits and cursor
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            max_x     <= screen_pkg::coord_t'(`DEFAULT_MAX_X);
            max_y     <= screen_pkg::coord_t'(`DEFAULT_MAX_Y);
            min_x     <= '0;
            min_y     <= '0;
            pos_x     <= '0;
            pos_y     <= '0;
            buttons   <= '0;
            pos_valid <= 1'b0;
        end
        else
        begin
            // Limit writes, position catches up on the next move
            if (setmax_x) max_x <= value;
            if (setmax_y) max_y <= value;
            if (setmin_x) min_x <= value;
            if (setmin_y) min_y <= value;
            pos_valid <= move_fire;
            if (move_fire)
            begin
                pos_x   <= clamp(sum_x, min_x, max_x);
                pos_y   <= clamp(sum_y, min_y, max_y);
                buttons <= move_data.buttons;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mouse_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module mouse_subsystem
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           game_on,
    input  wire logic [7:0]     byte_data,
    input  wire logic           byte_valid,
    output logic                byte_ready,
    output screen_pkg::coord_t  pos_x,
    output screen_pkg::coord_t  pos_y,
    output logic [`BTN_W-1:0]   buttons,
    output logic                pos_valid
);

    // Window limit writes
    screen_pkg::coord_t limit_value;
    logic               setmax_x;
    logic               setmax_y;
    logic               setmin_x;
    logic               setmin_y;

    // Packetizer to buffer
    mouse_pkg::move_t   pk_data;
    logic               pk_valid;
    logic               pk_ready;

    // Buffer to tracker
    mouse_pkg::move_t   fifo_data;
    logic               fifo_valid;
    logic               fifo_ready;

    ////////////////////////////////////////
    // Limit source
    ////////////////////////////////////////

    mouse_constrainer u_constrainer
    (
        .clk      (clk),
        .rst      (rst),
        .game_on  (game_on),
        .value    (limit_value),
        .setmax_x (setmax_x),
        .setmax_y (setmax_y),
        .setmin_x (setmin_x),
        .setmin_y (setmin_y)
    );

    ////////////////////////////////////////
    // Move path
    ////////////////////////////////////////

    move_packetizer u_packetizer
    (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .move_data  (pk_data),
        .move_valid (pk_valid),
        .move_ready (pk_ready)
    );

    // Absorbs moves while the game is paused
    move_fifo
    #(
        .payload_t (mouse_pkg::move_t),
        .DEPTH     (`MOVE_FIFO_DEPTH)
    )
    u_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .in_data   (pk_data),
        .in_valid  (pk_valid),
        .in_ready  (pk_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    position_tracker u_tracker
    (
        .clk        (clk),
        .rst        (rst),
        .game_on    (game_on),
        .value      (limit_value),
        .setmax_x   (setmax_x),
        .setmax_y   (setmax_y),
        .setmin_x   (setmin_x),
        .setmin_y   (setmin_y),
        .move_data  (fifo_data),
        .move_valid (fifo_valid),
        .move_ready (fifo_ready),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .buttons    (buttons),
        .pos_valid  (pos_valid)
    );

endmodule

`default_nettype wire

// ==== tb/mouse_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module mouse_subsystem_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 16;
    localparam int STALL_LIMIT = 20;
    // Directed, random, stray byte and fill phases
    localparam int NUM_PACKETS    = 5 + 20 + 1 + 6;
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * 8 + 400;

    logic               clk;
    logic               rst;
    logic               game_on;
    logic [7:0]         byte_data;
    logic               byte_valid;
    logic               byte_ready;
    screen_pkg::coord_t pos_x;
    screen_pkg::coord_t pos_y;
    logic [`BTN_W-1:0]  buttons;
    logic               pos_valid;

    int seed = 41720;
    int errors = 0;
    int sent_count = 0;
    int pulse_count = 0;
    // Reference cursor and window
    int mx = 0;
    int my = 0;
    int lim_min_x = 0;
    int lim_min_y = 0;
    int lim_max_x = `DEFAULT_MAX_X;
    int lim_max_y = `DEFAULT_MAX_Y;
    // Expected results, oldest first
    int exp_x_q[$];
    int exp_y_q[$];
    int exp_btn_q[$];
    // Entry under check at the next rising edge
    int exp_x = 0;
    int exp_y = 0;
    int exp_btn = 0;
    logic exp_pending = 1'b0;

    mouse_subsystem dut
    (
        .clk        (clk),
        .rst        (rst),
        .game_on    (game_on),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .buttons    (buttons),
        .pos_valid  (pos_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Reference model and checkers
    ////////////////////////////////////////

    function automatic int clamp_to(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    task automatic report_mismatch(input string name, input int expv, input int gotv);
        $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expv, gotv);
        errors++;
    endtask

    // New x adds dx, new y subtracts dy
    task automatic expect_move(input int dx, input int dy, input int btn);
        mx = clamp_to(mx + dx, lim_min_x, lim_max_x);
        my = clamp_to(my - dy, lim_min_y, lim_max_y);
        exp_x_q.push_back(mx);
        exp_y_q.push_back(my);
        exp_btn_q.push_back(btn);
        sent_count++;
    endtask

    // Pop one expected entry per pulse, checked at the next rising edge
    always @(negedge clk)
    begin
        exp_pending = 1'b0;
        if (pos_valid && exp_x_q.size() != 0)
        begin
            exp_x = exp_x_q.pop_front();
            exp_y = exp_y_q.pop_front();
            exp_btn = exp_btn_q.pop_front();
            exp_pending = 1'b1;
        end
        if (pos_valid)
            pulse_count++;
    end

    x_check: assert property (@(posedge clk) disable iff (rst) pos_valid |-> pos_x == exp_x)
        else report_mismatch("pos_x", $sampled(exp_x), $sampled(pos_x));
    y_check: assert property (@(posedge clk) disable iff (rst) pos_valid |-> pos_y == exp_y)
        else report_mismatch("pos_y", $sampled(exp_y), $sampled(pos_y));
    btn_check: assert property (@(posedge clk) disable iff (rst) pos_valid |-> buttons == exp_btn)
        else report_mismatch("buttons", $sampled(exp_btn), $sampled(buttons));
    extra_check: assert property (@(posedge clk) disable iff (rst) pos_valid |-> exp_pending)
        else
        begin
            $display("At %0t ns pos_valid pulsed with no move outstanding", $time);
            errors++;
        end
    // A move needs game_on high one cycle before its pulse
    idle_check: assert property (@(posedge clk) disable iff (rst) !$past(game_on) |-> !pos_valid)
        else
        begin
            $display("At %0t ns pos_valid pulsed while the game was off", $time);
            errors++;
        end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    // Gives up after STALL_LIMIT cycles of back-pressure
    task automatic send_byte(input logic [7:0] b, output bit ok);
        int waited;
        waited = 0;
        @(negedge clk);
        byte_data = b;
        byte_valid = 1'b1;
        while (!byte_ready && waited < STALL_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        ok = byte_ready;
        @(negedge clk);
        byte_valid = 1'b0;
    endtask

    // Header: sync bit 3, x sign bit 4, y sign bit 5, buttons 0 to 2
    task automatic send_packet(input int dx, input int dy, input logic [2:0] btn, output bit ok);
        logic [7:0] hdr;
        logic [8:0] dx9;
        logic [8:0] dy9;
        dx9 = dx[8:0];
        dy9 = dy[8:0];
        hdr = {2'b00, dy9[8], dx9[8], 1'b1, btn};
        send_byte(hdr, ok);
        if (ok)
            send_byte(dx9[7:0], ok);
        if (ok)
            send_byte(dy9[7:0], ok);
        if (ok)
            expect_move(dx, dy, btn);
    endtask

    task automatic send_random(output bit ok);
        logic [31:0] r;
        r = $random(seed);
        send_packet($signed(r[8:0]), $signed(r[20:12]), r[11:9], ok);
    endtask

    // Raise game_on and let the window limits load
    task automatic start_game();
        @(negedge clk);
        game_on = 1'b1;
        repeat (10) @(negedge clk);
        lim_min_x = `GAME_MIN_X;
        lim_min_y = `GAME_MIN_Y;
        lim_max_x = `GAME_MAX_X;
        lim_max_y = `GAME_MAX_Y;
    endtask

    task automatic wait_drain();
        while (exp_x_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        bit ok;
        int queued;
        rst = 1'b1;
        game_on = 1'b0;
        byte_data = 8'h00;
        byte_valid = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Idle state out of reset
        repeat (5)
        begin
            @(negedge clk);
            assert (!pos_valid) else report_mismatch("pos_valid", 0, pos_valid);
            assert (byte_ready) else report_mismatch("byte_ready", 1, byte_ready);
            assert (pos_x == 0) else report_mismatch("pos_x", 0, pos_x);
            assert (pos_y == 0) else report_mismatch("pos_y", 0, pos_y);
        end

        // Clamp into the window, then saturate at the max corner
        start_game();
        send_packet(5, -3, 3'b001, ok);
        send_packet(255, 0, 3'b010, ok);
        send_packet(255, 0, 3'b100, ok);
        send_packet(0, -256, 3'b000, ok);
        send_packet(0, -256, 3'b011, ok);
        wait_drain();
        assert (pos_x == `GAME_MAX_X) else report_mismatch("pos_x", `GAME_MAX_X, pos_x);
        assert (pos_y == `GAME_MAX_Y) else report_mismatch("pos_y", `GAME_MAX_Y, pos_y);

        repeat (20)
            send_random(ok);
        wait_drain();

        // Stray byte without sync bit in header position
        send_byte(8'h47, ok);
        send_packet(-40, 25, 3'b101, ok);
        wait_drain();

        // Pause the game until the FIFO and packetizer are full
        @(negedge clk);
        game_on = 1'b0;
        queued = 0;
        ok = 1'b1;
        while (ok && queued < 6)
        begin
            send_random(ok);
            if (ok)
                queued++;
        end
        assert (!byte_ready) else report_mismatch("byte_ready", 0, byte_ready);
        assert (queued == `MOVE_FIFO_DEPTH + 1)
            else report_mismatch("queued packets", `MOVE_FIFO_DEPTH + 1, queued);
        start_game();
        wait_drain();

        assert (pulse_count == sent_count)
            else report_mismatch("pos_valid pulses", sent_count, pulse_count);

        $display("Checks done with %0d errors", errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mouse_subsystem.f ====
+incdir+include
src/mouse_pkg.sv
src/screen_pkg.sv
src/mouse_constrainer.sv
src/move_packetizer.sv
src/move_fifo.sv
src/position_tracker.sv
src/mouse_subsystem.sv
tb/mouse_subsystem_tb.sv
